// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_phase_sweep
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then exit 1; fi
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: freq_table.sv
`timescale 1ns/10ps
`include "phase_sweep_defines.svh"

module freq_table
  (input logic clk125,
   input phase_sweep_pkg::table_wr_t tbl_wr,
   input phase_sweep_pkg::point_t point,
   output phase_sweep_pkg::freq_word_t freq_word
  );
  import phase_sweep_pkg::*;

  localparam int DEPTH = 2 ** `PS_ADDR_W; // one word per point

  freq_word_t mem [DEPTH]; // tuning words

  // system side, one word per strobe
  always_ff @(posedge clk125)
  begin
    if (tbl_wr.wren)
      mem[tbl_wr.addr] <= tbl_wr.data;
  end

  // word follows the sequencer point with no clock delay,
  // so the synthesiser retunes as soon as point steps
  assign freq_word = mem[point];

endmodule

// File: phase_counter.sv
`timescale 1ns/10ps
`include "phase_sweep_defines.svh"

module phase_counter
  (input logic clk125,
   input logic areset_n,
   input logic [`PS_CYC_W-1:0] num_cycles,
   input logic measure_start,
   input logic cross_a,
   input logic cross_b,
   output logic measure_done,
   output phase_sweep_pkg::phase_t measured_phase
  );
  import phase_sweep_pkg::*;

  typedef enum logic [1:0] {M_IDLE, M_WAIT_FIRST, M_LAG_COUNT} meas_state_t;

  meas_state_t state;
  logic [`PS_CNT_W-1:0] lag_cnt; // cycles since the opening crossing
  logic b_first; // sign flag, set when B opened the period
  logic [`PS_CYC_W-1:0] period_cnt; // closed periods
  logic last_period;
  logic closing; // the other channel crossed
  phase_t lag_signed;

  assign last_period = (period_cnt == num_cycles);
  assign closing = b_first ? cross_a : cross_b;
  assign lag_signed = b_first ? -phase_t'(lag_cnt) : phase_t'(lag_cnt);

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state <= M_IDLE;
      lag_cnt <= '0;
      b_first <= 1'b0;
      period_cnt <= '0;
      measure_done <= 1'b0;
      measured_phase <= '0;
    end
    else
    begin
      measure_done <= 1'b0; // strobe
      case (state)
        M_IDLE:
          if (measure_start)
          begin
            period_cnt <= '0;
            state <= M_WAIT_FIRST;
          end
        M_WAIT_FIRST:
          if (cross_a && cross_b)
          begin
            // channels in phase, period opens and closes at once
            measured_phase <= '0;
            period_cnt <= period_cnt + 1'b1;
            if (last_period)
            begin
              measure_done <= 1'b1;
              state <= M_IDLE;
            end
          end
          else if (cross_a || cross_b)
          begin
            b_first <= cross_b; // negative lag when B leads
            lag_cnt <= `PS_CNT_W'(1); // counted up to the closing cycle
            state <= M_LAG_COUNT;
          end
        M_LAG_COUNT:
          if (closing)
          begin
            measured_phase <= lag_signed; // last period wins
            period_cnt <= period_cnt + 1'b1;
            if (last_period)
            begin
              measure_done <= 1'b1;
              state <= M_IDLE;
            end
            else
              state <= M_WAIT_FIRST;
          end
          else if (lag_cnt != '1)
            lag_cnt <= lag_cnt + 1'b1; // saturate on a missing channel
        default:
          state <= M_IDLE;
      endcase
    end
  end

endmodule

// File: phase_sweep_asserts.sv
`timescale 1ns/10ps

module phase_sweep_asserts
  (input logic clk125,
   input logic areset_n,
   input phase_sweep_pkg::phase_result_t result,
   input phase_sweep_pkg::point_t num_points,
   input logic sweep_done
  );

  // result strobe is a single cycle
  valid_one_cycle: assert property (@(posedge clk125) disable iff (!areset_n)
    result.valid |=> !result.valid)
    else $error("result.valid high for more than one cycle");

  valid_not_done: assert property (@(posedge clk125) disable iff (!areset_n)
    !(result.valid && sweep_done))
    else $error("result.valid together with sweep_done");

  // point stays inside the configured sweep
  point_in_range: assert property (@(posedge clk125) disable iff (!areset_n)
    result.valid |-> (result.point < num_points))
    else $error("result.point outside num_points");

endmodule

bind phase_sweep_top phase_sweep_asserts u_asserts
  (.clk125(clk125), .areset_n(areset_n), .result(result),
   .num_points(cfg.num_points), .sweep_done(sweep_done));

// File: phase_sweep_defines.svh
`ifndef PHASE_SWEEP_DEFINES_SVH
`define PHASE_SWEEP_DEFINES_SVH

// datapath widths
`define PS_SAMPLE_W 14 // adc and dac samples
`define PS_DATA_W 32 // synthesiser tuning word
`define PS_ADDR_W 8 // table depth 256 points
`define PS_CNT_W 16 // dead-band and lag counters
`define PS_CYC_W 3 // periods per measurement

// default run-time configuration
`define PS_DEF_NUM_POINTS 8
`define PS_DEF_NUM_CYCLES 2 // measure over 3 periods
`define PS_DEF_DET_WIDTH 8 // 9 non-negative samples to arm

// full-scale sample levels
`define PS_SAMPLE_MAX ((1 << (`PS_SAMPLE_W - 1)) - 1)
`define PS_SAMPLE_MIN (-(1 << (`PS_SAMPLE_W - 1)))

`endif

// File: phase_sweep_pkg.sv
`include "phase_sweep_defines.svh"

package phase_sweep_pkg;

  typedef logic signed [`PS_SAMPLE_W-1:0] sample_t; // adc / ref sample
  typedef logic [`PS_DATA_W-1:0] freq_word_t; // tuning word
  typedef logic [`PS_ADDR_W-1:0] point_t; // sweep point index
  typedef logic signed [`PS_CNT_W-1:0] phase_t; // lag in clk125 cycles

  // run-time sweep setup, held while start is high
  typedef struct packed {
    point_t num_points; // points per sweep
    logic [`PS_CYC_W-1:0] num_cycles; // periods per measurement, minus one
    logic [`PS_CNT_W-1:0] det_width; // dead-band of the detectors
  } sweep_cfg_t;

  // system write port of the frequency table
  typedef struct packed {
    logic wren;
    point_t addr;
    freq_word_t data;
  } table_wr_t;

  // one result per sweep point
  typedef struct packed {
    logic valid; // single-cycle strobe
    point_t point;
    phase_t phase;
  } phase_result_t;

endpackage

// File: phase_sweep_top.sv
`timescale 1ns/10ps

module phase_sweep_top
  (input logic clk125,
   input logic areset_n,
   input logic start,
   input phase_sweep_pkg::sweep_cfg_t cfg,
   input phase_sweep_pkg::table_wr_t tbl_wr,
   input phase_sweep_pkg::sample_t ref_sample,
   input phase_sweep_pkg::sample_t adc_a,
   input phase_sweep_pkg::sample_t adc_b,
   output phase_sweep_pkg::freq_word_t freq_word,
   output phase_sweep_pkg::phase_result_t result,
   output logic sweep_done
  );
  import phase_sweep_pkg::*;

  point_t point; // current sweep point
  logic cross_ref; // reference falling crossing
  logic cross_a;
  logic cross_b;
  logic measure_start;
  logic measure_done;
  phase_t measured_phase;

  // tuning word for the external synthesiser
  freq_table u_freq_table
    (.clk125(clk125),
     .tbl_wr(tbl_wr),
     .point(point),
     .freq_word(freq_word));

  // same dead-band on all three channels
  sign_crossing_detector det_ref
    (.clk125(clk125),
     .areset_n(areset_n),
     .sample(ref_sample),
     .det_width(cfg.det_width),
     .crossing(cross_ref));

  sign_crossing_detector det_a
    (.clk125(clk125),
     .areset_n(areset_n),
     .sample(adc_a),
     .det_width(cfg.det_width),
     .crossing(cross_a));

  sign_crossing_detector det_b
    (.clk125(clk125),
     .areset_n(areset_n),
     .sample(adc_b),
     .det_width(cfg.det_width),
     .crossing(cross_b));

  sweep_sequencer u_sweep_sequencer
    (.clk125(clk125),
     .areset_n(areset_n),
     .start(start),
     .cfg(cfg),
     .cross_ref(cross_ref),
     .measure_done(measure_done),
     .measured_phase(measured_phase),
     .measure_start(measure_start),
     .point(point),
     .result(result),
     .sweep_done(sweep_done));

  phase_counter u_phase_counter
    (.clk125(clk125),
     .areset_n(areset_n),
     .num_cycles(cfg.num_cycles),
     .measure_start(measure_start),
     .cross_a(cross_a),
     .cross_b(cross_b),
     .measure_done(measure_done),
     .measured_phase(measured_phase));

endmodule

// File: sign_crossing_detector.sv
`timescale 1ns/10ps
`include "phase_sweep_defines.svh"

module sign_crossing_detector
  (input logic clk125,
   input logic areset_n,
   input phase_sweep_pkg::sample_t sample,
   input logic [`PS_CNT_W-1:0] det_width,
   output logic crossing
  );
  import phase_sweep_pkg::*;

  typedef enum logic [1:0] {WAITING, COUNTING, ARMED} det_state_t;

  det_state_t state;
  sample_t sample_q; // input register
  logic [`PS_CNT_W-1:0] count; // non-negative run length
  logic negative;

  assign negative = sample_q[`PS_SAMPLE_W-1]; // sign bit only

  always_ff @(posedge clk125 or negedge areset_n)
    if (!areset_n)
      sample_q <= '0;
    else
      sample_q <= sample;

  // dead-band keeps noise around zero from firing twice
  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state <= WAITING;
      count <= '0;
      crossing <= 1'b0;
    end
    else
    begin
      crossing <= 1'b0; // pulse lasts one cycle
      case (state)
        WAITING:
          if (!negative)
          begin
            count <= `PS_CNT_W'(1); // first sample of the run
            state <= (det_width == '0) ? ARMED : COUNTING;
          end
        COUNTING:
          if (negative)
          begin
            count <= '0; // run broken
            state <= WAITING;
          end
          else if (count >= det_width)
            state <= ARMED; // det_width+1 samples seen
          else
            count <= count + 1'b1;
        ARMED:
          if (negative)
          begin
            crossing <= 1'b1; // falling crossing
            count <= '0;
            state <= WAITING;
          end
        default:
          state <= WAITING;
      endcase
    end
  end

endmodule

// File: src.f
+incdir+.
phase_sweep_pkg.sv
sign_crossing_detector.sv
freq_table.sv
sweep_sequencer.sv
phase_counter.sv
phase_sweep_top.sv
phase_sweep_asserts.sv
tb_phase_sweep.sv

// File: sweep_sequencer.sv
`timescale 1ns/10ps
`include "phase_sweep_defines.svh"

module sweep_sequencer
  (input logic clk125,
   input logic areset_n,
   input logic start,
   input phase_sweep_pkg::sweep_cfg_t cfg,
   input logic cross_ref,
   input logic measure_done,
   input phase_sweep_pkg::phase_t measured_phase,
   output logic measure_start,
   output phase_sweep_pkg::point_t point,
   output phase_sweep_pkg::phase_result_t result,
   output logic sweep_done
  );
  import phase_sweep_pkg::*;

  typedef enum logic [1:0] {IDLE, SETTLE, MEASURE, DONE} seq_state_t;

  seq_state_t state;
  logic [`PS_CYC_W-1:0] settle_cnt; // ref periods seen so far
  logic [$bits(point_t):0] point_inc; // one bit wider, no wrap at 255
  logic last_point;

  assign point_inc = {1'b0, point} + 1'b1;
  assign last_point = (point_inc >= {1'b0, cfg.num_points}); // no point+1 left
  assign sweep_done = (state == DONE); // held until start drops

  always_ff @(posedge clk125 or negedge areset_n)
  begin
    if (!areset_n)
    begin
      state <= IDLE;
      settle_cnt <= '0;
      point <= '0;
      measure_start <= 1'b0;
      result <= '0;
    end
    else
    begin
      measure_start <= 1'b0; // strobes
      result.valid <= 1'b0;
      case (state)
        IDLE:
        begin
          settle_cnt <= '0;
          if (start)
            state <= SETTLE;
        end
        SETTLE:
          // let the synthesiser settle on the new word
          if (cross_ref)
          begin
            if (settle_cnt == cfg.num_cycles)
            begin
              settle_cnt <= '0;
              measure_start <= 1'b1; // next cycle after last ref crossing
              state <= MEASURE;
            end
            else
              settle_cnt <= settle_cnt + 1'b1;
          end
        MEASURE:
          if (measure_done)
          begin
            result.valid <= 1'b1;
            result.point <= point; // point still at the measured one
            result.phase <= measured_phase;
          end
          else if (result.valid)
          begin
            // step one cycle after the result, keeps valid off sweep_done
            if (last_point)
              state <= DONE;
            else
            begin
              point <= point_inc[$bits(point_t)-1:0];
              state <= SETTLE;
            end
          end
        DONE:
          if (!start)
          begin
            point <= '0; // table back to first word
            state <= IDLE;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

endmodule

// File: tb_phase_sweep.sv
`timescale 1ns/10ps
`include "phase_sweep_defines.svh"

module tb_phase_sweep;
  import phase_sweep_pkg::*;

  localparam int NUM_POINTS = `PS_DEF_NUM_POINTS; // table entries used per sweep
  localparam int CH_OFFSET = 16; // adc channels trail the reference
  localparam int SWEEP_LIMIT = 10000; // cycles allowed for one sweep

  logic clk125 = 1'b0;
  logic areset_n;
  logic start;
  sweep_cfg_t cfg;
  table_wr_t tbl_wr;
  sample_t ref_sample;
  sample_t adc_a;
  sample_t adc_b;
  freq_word_t freq_word;
  phase_result_t result;
  logic sweep_done;

  logic [31:0] lfsr = 32'h228f77da;
  freq_word_t tbl_model [2 ** `PS_ADDR_W]; // words written to the dut
  int lag_d = 1; // cycles between the two channels
  int lead_order = 0; // 0 a leads, 1 b leads, 2 in phase
  int first_order;
  int result_count; // results seen in the current sweep
  int error_count = 0;
  int test_count = 0;
  int failed_count = 0;
  int test_err_base = 0;
  bit timed_out = 1'b0;
  string test_name = "reset";

  phase_sweep_top dut0
    (.clk125(clk125),
     .areset_n(areset_n),
     .start(start),
     .cfg(cfg),
     .tbl_wr(tbl_wr),
     .ref_sample(ref_sample),
     .adc_a(adc_a),
     .adc_b(adc_b),
     .freq_word(freq_word),
     .result(result),
     .sweep_done(sweep_done));

  always #20 clk125 = ~clk125; // 25 MHz in sim, period 40 ns

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // expected lag, positive when A crosses first
  function automatic int expected_phase(input int lag, input int order);
    case (order)
      0: return lag;
      1: return -lag;
      default: return 0; // identical channels
    endcase
  endfunction

  // full-scale square wave, falling edge at t mod 64 == 32
  function automatic sample_t square(input int unsigned t);
    if ((t & 32'd63) < 32'd32)
      return sample_t'(`PS_SAMPLE_MAX);
    else
      return sample_t'(`PS_SAMPLE_MIN);
  endfunction

  task automatic check_value(input string what, input longint expected, input longint actual);
    if (expected != actual)
    begin
      error_count++;
      $display("[ERROR] %s %s expected %0d actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err_base = error_count;
  endtask

  task automatic end_test();
    test_count++;
    if (timed_out || error_count != test_err_base)
    begin
      failed_count++;
      $display("test %s: failed, %0d errors", test_name, error_count - test_err_base);
    end
    else
      $display("test %s: ok (lag %0d)", test_name, expected_phase(lag_d, lead_order));
  endtask

  task automatic wait_sweep_done(input logic level, input int limit);
    int cycles;
    cycles = 0;
    do
    begin
      @(negedge clk125); // outputs settled mid-cycle
      cycles++;
    end
    while (sweep_done !== level && cycles < limit);
    if (sweep_done !== level)
    begin
      timed_out = 1'b1;
      $display("timeout: sweep_done did not become %0b within %0d cycles in test %s",
               level, limit, test_name);
    end
  endtask

  task automatic load_table();
    freq_word_t w;
    for (int i = 0; i < NUM_POINTS; i++)
    begin
      w = rand_bits(32);
      tbl_model[i] = w;
      @(posedge clk125);
      tbl_wr <= '{wren: 1'b1, addr: point_t'(i), data: w};
    end
    @(posedge clk125);
    tbl_wr <= '0; // strobe off
  endtask

  task automatic run_sweep(input string name, input int order);
    begin_test(name);
    @(negedge clk125); // away from the stimulus edge
    lead_order = order;
    lag_d = (order == 2) ? 0 : int'(rand_bits(4)) % 15 + 1; // 1 to 15
    check_value("freq_word_point0", longint'(tbl_model[0]), longint'(freq_word));
    @(posedge clk125);
    start <= 1'b1;
    wait_sweep_done(1'b1, SWEEP_LIMIT);
    if (!timed_out)
    begin
      check_value("result_count", longint'(NUM_POINTS), longint'(result_count));
      repeat (8)
      begin
        @(negedge clk125);
        check_value("sweep_done_hold", 1, longint'(sweep_done)); // held while start
      end
      @(posedge clk125);
      start <= 1'b0;
      wait_sweep_done(1'b0, 4);
    end
    end_test();
  endtask

  // sample streams, trailing channel delayed by lag_d
  initial
  begin
    int unsigned tick;
    tick = 0;
    ref_sample = '0;
    adc_a = '0;
    adc_b = '0;
    forever
    begin
      @(posedge clk125);
      tick++;
      ref_sample <= square(tick);
      if (lead_order == 1)
      begin
        adc_b <= square(tick - CH_OFFSET);
        adc_a <= square(tick - CH_OFFSET - lag_d);
      end
      else
      begin
        adc_a <= square(tick - CH_OFFSET);
        adc_b <= square(tick - CH_OFFSET - lag_d); // lag_d 0 when in phase
      end
    end
  end

  // scoreboard on result.valid
  initial
  begin
    result_count = 0;
    forever
    begin
      @(negedge clk125);
      if (!start)
        result_count = 0;
      else if (result.valid)
      begin
        check_value("point", longint'(result_count), longint'(result.point));
        check_value("phase", longint'(expected_phase(lag_d, lead_order)),
                    longint'(result.phase));
        check_value("freq_word", longint'(tbl_model[result_count]), longint'(freq_word));
        result_count++;
      end
    end
  end

  initial
  begin
    areset_n = 1'b0;
    start = 1'b0;
    cfg = '0;
    tbl_wr = '0;
    repeat (16) @(posedge clk125);
    areset_n <= 1'b1;
    begin_test("reset");
    @(negedge clk125);
    check_value("result_valid", 0, longint'(result.valid));
    check_value("sweep_done", 0, longint'(sweep_done));
    end_test();
    @(posedge clk125);
    cfg <= '{num_points: point_t'(NUM_POINTS),
             num_cycles: `PS_CYC_W'(`PS_DEF_NUM_CYCLES),
             det_width: `PS_CNT_W'(`PS_DEF_DET_WIDTH)};
    load_table();
    first_order = int'(rand_bits(1)); // which channel leads first
    run_sweep(first_order == 1 ? "b_leads" : "a_leads", first_order);
    if (!timed_out)
      run_sweep(first_order == 1 ? "a_leads" : "b_leads", 1 - first_order);
    if (!timed_out)
      run_sweep("in_phase", 2);
    $display("tests run %0d, failed %0d, errors %0d", test_count, failed_count, error_count);
    if (timed_out || error_count != 0)
      $display("*** TEST FAILED ***");
    else
      $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
